// ==== hdl/wb_pkg.sv ====
// Instruction port of a read-only Wishbone master; we and dat toward memory are always zero
package wb_pkg;

    // ----------------------------------------
    // Request, master to memory
    // ----------------------------------------

    // Held with a stable adr until ack comes back
    // Widths follow a 32-bit classic Wishbone port
    typedef struct packed {
        // Bus cycle in progress
        logic        cyc;
        // Transfer strobe
        logic        stb;
        // Write enable, tied low by this master
        logic        we;
        // Byte address, word aligned
        logic [31:0] adr;
        // Write data, unused here
        logic [31:0] dat;
    } wb_req_t;

    // ----------------------------------------
    // Response, memory to master
    // ----------------------------------------

    // Data is only meaningful in the ack cycle
    typedef struct packed {
        // Transfer finished this cycle
        logic        ack;
        // Read data
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

// ==== hdl/rv_pkg.sv ====
// RV32I base encodings only; no compressed forms, no CSR or system opcodes
package rv_pkg;

    // ----------------------------------------
    // Major opcodes, bits 6:0
    // ----------------------------------------
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // ----------------------------------------
    // Instruction formats
    // ----------------------------------------

    // One word, six ways to slice it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            logic [6:0] opcode;
        } s_fmt;
        // Branch offset bits are scrambled, bit 0 implied zero
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

    // Coarse class for the back end
    typedef enum logic [2:0] {
        C_ALU_R,
        C_ALU_I,
        C_LOAD,
        C_STORE,
        C_BRANCH,
        C_UPPER,
        C_JUMP,
        C_ILLEGAL
    } instr_class_e;

    // Decode output, raw fields always taken from their fixed positions
    typedef struct packed {
        logic [31:0]  pc;
        logic [31:0]  raw;
        instr_class_e cls;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic [2:0]   funct3;
        logic [6:0]   funct7;
        logic [31:0]  imm;
    } dec_instr_t;

    // Fetch register between IF and ID
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
    } fetch_t;

endpackage

// ==== hdl/load_unit.sv ====
// One bus cycle at a time; stb drops for a cycle after each ack, abandoned reads drain first
`timescale 1ns/1ns

module load_unit import wb_pkg::*; (
    input  logic        clk,
    input  logic        rstn_i,
    input  logic        read_i,
    input  logic [31:0] addr_i,
    input  logic        halt_i,
    output logic        valid_o,
    output logic [31:0] data_o,
    output wb_req_t     wb_req_o,
    input  wb_rsp_t     wb_rsp_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_DRAIN
    } state_e;

    state_e      state_q;
    logic [31:0] adr_q;
    logic        gap_q;
    logic        hold_q;
    logic [31:0] hold_data_q;
    logic        start;
    logic        open;
    logic        live;
    logic        done;

    // New cycle straight from idle, address taken live this cycle
    assign start = (state_q == S_IDLE) && read_i && !halt_i && !gap_q && !hold_q;
    assign open  = start || (state_q == S_BUSY) || (state_q == S_DRAIN);
    // Cycles whose data still has a taker
    assign live  = start || (state_q == S_BUSY);
    assign done  = open && wb_rsp_i.ack;

    assign wb_req_o.cyc = open;
    assign wb_req_o.stb = open;
    assign wb_req_o.we  = 1'b0;
    assign wb_req_o.adr = (state_q == S_IDLE) ? addr_i : adr_q;
    assign wb_req_o.dat = 32'h0;

    // Word goes out only if fetch still asks for it
    assign valid_o = read_i && !halt_i && (hold_q || (live && done));
    assign data_o  = hold_q ? hold_data_q : wb_rsp_i.dat;

    // ----------------------------------------
    // Cycle control
    // ----------------------------------------
    always_ff @(posedge clk, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= S_IDLE;
            gap_q   <= 1'b0;
            hold_q  <= 1'b0;
        end else begin
            gap_q <= done;
            // Held word is used or dropped on the first free cycle
            if (!halt_i)
                hold_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start && !wb_rsp_i.ack)
                        state_q <= S_BUSY;
                end
                S_BUSY: begin
                    if (wb_rsp_i.ack) begin
                        state_q <= S_IDLE;
                        // Halted, park the word for later
                        if (halt_i)
                            hold_q <= 1'b1;
                    end else if (!halt_i && !read_i) begin
                        state_q <= S_DRAIN;
                    end
                end
                default: begin
                    if (wb_rsp_i.ack)
                        state_q <= S_IDLE;
                end
            endcase
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (start)
            adr_q <= addr_i;
        if ((state_q == S_BUSY) && wb_rsp_i.ack && halt_i)
            hold_data_q <= wb_rsp_i.dat;
    end

endmodule

// ==== hdl/if_stage.sv ====
// Fetch stage; halt freezes pc and register, flush beats a word arriving in the same cycle
`timescale 1ns/1ns

module if_stage import rv_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rstn_i,
    input  logic        halt_i,
    // Redirect from decode
    input  logic        flush_i,
    input  logic [31:0] pc_i,
    // Toward decode
    input  logic        ack_i,
    output fetch_t      fetch_o,
    // Load unit side
    output logic        read_o,
    output logic [31:0] addr_o,
    input  logic        rd_valid_i,
    input  logic [31:0] rd_data_i,
    // Debug
    output logic [31:0] dbg_pc_o
);

    logic [31:0] pc_q;
    fetch_t      fetch_q;
    fetch_t      fetch_n;
    logic        incr_pc;
    logic        read;

    assign fetch_o  = fetch_q;
    assign read_o   = read;
    assign addr_o   = pc_q;
    assign dbg_pc_o = pc_q;

    // ----------------------------------------
    // Next fetch register
    // ----------------------------------------
    always_comb begin
        fetch_n = fetch_q;
        incr_pc = 1'b0;
        read    = 1'b0;

        // Decode took the current word
        if (ack_i)
            fetch_n.valid = 1'b0;

        // Ask for a word when a slot is or becomes free
        if (!fetch_q.valid || ack_i) begin
            read = 1'b1;
            if (rd_valid_i) begin
                fetch_n.valid = 1'b1;
                fetch_n.instr = rd_data_i;
                fetch_n.pc    = pc_q;
                incr_pc       = 1'b1;
            end
        end

        // Wrong path, drop everything and stop asking
        if (flush_i) begin
            fetch_n.valid = 1'b0;
            incr_pc       = 1'b0;
            read          = 1'b0;
        end
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge clk, negedge rstn_i) begin
        if (!rstn_i) begin
            fetch_q <= '0;
            pc_q    <= RESET_PC;
        end else if (!halt_i) begin
            fetch_q <= fetch_n;
            // Target first, otherwise step past the captured word
            if (flush_i)
                pc_q <= pc_i;
            else if (incr_pc)
                pc_q <= pc_q + 32'd4;
        end
    end

endmodule

// ==== hdl/id_stage.sv ====
// Decode stage; resolves only JAL, JALR and unknown opcodes come out as C_ILLEGAL
`timescale 1ns/1ns

module id_stage import rv_pkg::*; (
    input  logic        clk,
    input  logic        rstn_i,
    input  logic        halt_i,
    // From fetch
    input  fetch_t      fetch_i,
    output logic        fetch_ack_o,
    // To consumer
    input  logic        ack_i,
    output logic        valid_o,
    output dec_instr_t  instr_o,
    // Jump back into fetch
    output logic        redirect_o,
    output logic [31:0] target_o
);

    instr_u      word;
    dec_instr_t  dec_n;
    dec_instr_t  dec_q;
    logic        valid_q;
    logic        accept;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign word = fetch_i.instr;

    // ----------------------------------------
    // Immediates, every format at once
    // ----------------------------------------
    assign imm_i = {{20{word.i_fmt.imm11_0[11]}}, word.i_fmt.imm11_0};
    assign imm_s = {{20{word.s_fmt.imm11_5[6]}}, word.s_fmt.imm11_5, word.s_fmt.imm4_0};
    assign imm_b = {{19{word.b_fmt.imm12}}, word.b_fmt.imm12, word.b_fmt.imm11,
                    word.b_fmt.imm10_5, word.b_fmt.imm4_1, 1'b0};
    assign imm_u = {word.u_fmt.imm31_12, 12'h000};
    assign imm_j = {{11{word.j_fmt.imm20}}, word.j_fmt.imm20, word.j_fmt.imm19_12,
                    word.j_fmt.imm11, word.j_fmt.imm10_1, 1'b0};

    // Class and fields of the word in the fetch register
    always_comb begin
        dec_n.pc     = fetch_i.pc;
        dec_n.raw    = fetch_i.instr;
        // Fixed bit positions, whatever the format
        dec_n.rd     = word.r_fmt.rd;
        dec_n.rs1    = word.r_fmt.rs1;
        dec_n.rs2    = word.r_fmt.rs2;
        dec_n.funct3 = word.r_fmt.funct3;
        dec_n.funct7 = word.r_fmt.funct7;
        dec_n.cls    = C_ILLEGAL;
        dec_n.imm    = 32'h0;
        case (word.r_fmt.opcode)
            OP_REG:    dec_n.cls = C_ALU_R;
            OP_IMM: begin
                dec_n.cls = C_ALU_I;
                dec_n.imm = imm_i;
            end
            OP_LOAD: begin
                dec_n.cls = C_LOAD;
                dec_n.imm = imm_i;
            end
            OP_STORE: begin
                dec_n.cls = C_STORE;
                dec_n.imm = imm_s;
            end
            OP_BRANCH: begin
                dec_n.cls = C_BRANCH;
                dec_n.imm = imm_b;
            end
            OP_LUI, OP_AUIPC: begin
                dec_n.cls = C_UPPER;
                dec_n.imm = imm_u;
            end
            OP_JAL: begin
                dec_n.cls = C_JUMP;
                dec_n.imm = imm_j;
            end
            // No register file here, so no indirect jump
            OP_JALR:   dec_n.cls = C_ILLEGAL;
            default:   dec_n.cls = C_ILLEGAL;
        endcase
    end

    // ----------------------------------------
    // Handshake and redirect
    // ----------------------------------------

    // Take a word when the output slot is free or leaving
    assign accept      = fetch_i.valid && !halt_i && (!valid_q || ack_i);
    assign fetch_ack_o = accept;
    assign valid_o     = valid_q && !halt_i;
    assign instr_o     = dec_q;

    // Same cycle as accept, fetch reloads at the next edge
    assign redirect_o = accept && (dec_n.cls == C_JUMP);
    assign target_o   = fetch_i.pc + imm_j;

    always_ff @(posedge clk, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (!halt_i) begin
            if (accept)
                valid_q <= 1'b1;
            else if (ack_i)
                valid_q <= 1'b0;
        end
    end

    // Decoded payload
    always_ff @(posedge clk) begin
        if (accept)
            dec_q <= dec_n;
    end

endmodule

// ==== hdl/frontend_top.sv ====
// Front end top; instruction memory lives outside, RESET_PC must be word aligned
`timescale 1ns/1ns

module frontend_top import wb_pkg::*, rv_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rstn_i,
    input  logic        halt_i,
    // Decoded stream
    input  logic        ack_i,
    output logic        valid_o,
    output dec_instr_t  instr_o,
    // Instruction bus
    output wb_req_t     wb_req_o,
    input  wb_rsp_t     wb_rsp_i,
    // Fetch pc
    output logic [31:0] dbg_pc_o
);

    fetch_t      fetch;
    logic        fetch_ack;
    logic        redirect;
    logic [31:0] target;
    logic        read;
    logic [31:0] read_addr;
    logic        read_valid;
    logic [31:0] read_data;

    // ----------------------------------------
    // Fetch and its bus master
    // ----------------------------------------
    if_stage #(
        .RESET_PC ( RESET_PC )
    ) if_i (
        .clk        ( clk        ),
        .rstn_i     ( rstn_i     ),
        .halt_i     ( halt_i     ),
        .flush_i    ( redirect   ),
        .pc_i       ( target     ),
        .ack_i      ( fetch_ack  ),
        .fetch_o    ( fetch      ),
        .read_o     ( read       ),
        .addr_o     ( read_addr  ),
        .rd_valid_i ( read_valid ),
        .rd_data_i  ( read_data  ),
        .dbg_pc_o   ( dbg_pc_o   )
    );

    load_unit lu_i (
        .clk      ( clk        ),
        .rstn_i   ( rstn_i     ),
        .read_i   ( read       ),
        .addr_i   ( read_addr  ),
        .halt_i   ( halt_i     ),
        .valid_o  ( read_valid ),
        .data_o   ( read_data  ),
        .wb_req_o ( wb_req_o   ),
        .wb_rsp_i ( wb_rsp_i   )
    );

    // Decode, also the source of jump redirects
    id_stage id_i (
        .clk         ( clk       ),
        .rstn_i      ( rstn_i    ),
        .halt_i      ( halt_i    ),
        .fetch_i     ( fetch     ),
        .fetch_ack_o ( fetch_ack ),
        .ack_i       ( ack_i     ),
        .valid_o     ( valid_o   ),
        .instr_o     ( instr_o   ),
        .redirect_o  ( redirect  ),
        .target_o    ( target    )
    );

endmodule

// ==== verification/frontend_chk.sv ====
// Bus and decode output protocol checks, bound into frontend_top; sampled on posedge clk
`timescale 1ns/1ns

module frontend_chk import wb_pkg::*, rv_pkg::*; (
    input logic       clk,
    input logic       rstn_i,
    input logic       ack_i,
    input logic       valid_i,
    input dec_instr_t instr_i,
    input wb_req_t    wb_req_i,
    input wb_rsp_t    wb_rsp_i
);

    // Number of failed assertions so far
    int unsigned fail_cnt = 0;

    // ----------------------------------------
    // Instruction bus
    // ----------------------------------------

    // Open request stays up with the same address until ack
    req_held: assert property (@(posedge clk) disable iff (!rstn_i)
        wb_req_i.stb && !wb_rsp_i.ack |=> wb_req_i.stb && $stable(wb_req_i.adr))
    else begin
        fail_cnt++;
        $error("bus request dropped or address changed before ack");
    end

    // ----------------------------------------
    // Decode output
    // ----------------------------------------

    // Item waiting for the consumer must not change
    out_held: assert property (@(posedge clk) disable iff (!rstn_i)
        valid_i && !ack_i |=> $stable(instr_i))
    else begin
        fail_cnt++;
        $error("decoded item changed while waiting for ack");
    end

    // First cycle out of reset has nothing to offer
    quiet_boot: assert property (@(posedge clk) $rose(rstn_i) |-> !valid_i)
    else begin
        fail_cnt++;
        $error("valid_o high in the first cycle after reset");
    end

endmodule

bind frontend_top frontend_chk chk_i (
    .clk      ( clk      ),
    .rstn_i   ( rstn_i   ),
    .ack_i    ( ack_i    ),
    .valid_i  ( valid_o  ),
    .instr_i  ( instr_o  ),
    .wb_req_i ( wb_req_o ),
    .wb_rsp_i ( wb_rsp_i )
);

// ==== verification/tb_frontend.sv ====
// UUT boots at 0x100; memory model behind the bus answers mapped words only, 0 to 3 wait states
`timescale 1ns/1ns

module tb_frontend import wb_pkg::*, rv_pkg::*; ();

    localparam int N_ROWS  = 14;
    localparam int N_WORDS = 19;
    localparam int TIMEOUT = N_ROWS * 16 + 100;

    logic        clk;
    logic        rstn_i;
    logic        halt_i;
    logic        ack_i;
    logic        valid_o;
    dec_instr_t  instr_o;
    wb_req_t     wb_req_o;
    wb_rsp_t     wb_rsp_i;
    logic [31:0] dbg_pc_o;

    logic [31:0] lfsr;
    logic [31:0] bits;
    logic [31:0] prog_adr [N_WORDS];
    logic [31:0] prog_dat [N_WORDS];
    dec_instr_t  exp_tab [N_ROWS];
    int          row;
    int          cycles;
    int          halt_left;
    int          waits_left;
    logic        req_seen;

    frontend_top #(
        .RESET_PC ( 32'h0000_0100 )
    ) UUT (
        .clk      ( clk      ),
        .rstn_i   ( rstn_i   ),
        .halt_i   ( halt_i   ),
        .ack_i    ( ack_i    ),
        .valid_o  ( valid_o  ),
        .instr_o  ( instr_o  ),
        .wb_req_o ( wb_req_o ),
        .wb_rsp_i ( wb_rsp_i ),
        .dbg_pc_o ( dbg_pc_o )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            fail_run($sformatf("ERR %0t ns: %s is %08h, expected %08h", $time, what, got, exp));
    endtask

    task automatic set_word(input int idx, input logic [31:0] adr, input logic [31:0] dat);
        prog_adr[idx] = adr;
        prog_dat[idx] = dat;
    endtask

    task automatic set_row(input int idx, input logic [31:0] pc, input logic [31:0] raw,
                           input instr_class_e cls, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [2:0] f3, input logic [6:0] f7,
                           input logic [31:0] imm);
        exp_tab[idx].pc     = pc;
        exp_tab[idx].raw    = raw;
        exp_tab[idx].cls    = cls;
        exp_tab[idx].rd     = rd;
        exp_tab[idx].rs1    = rs1;
        exp_tab[idx].rs2    = rs2;
        exp_tab[idx].funct3 = f3;
        exp_tab[idx].funct7 = f7;
        exp_tab[idx].imm    = imm;
    endtask

    task automatic lookup_word(input logic [31:0] adr, output logic [31:0] dat);
        int i;
        logic found;
        found = 1'b0;
        dat   = '0;
        for (i = 0; i < N_WORDS; i++) begin
            if (prog_adr[i] == adr) begin
                dat   = prog_dat[i];
                found = 1'b1;
            end
        end
        if (!found)
            fail_run($sformatf("Fetch from unmapped address %08h", adr));
    endtask

    // Memory side of one bus cycle with wait states drawn per request
    task automatic bus_respond();
        wb_rsp_t     rsp;
        logic [31:0] w;
        rsp = '0;
        if (wb_req_o.cyc && wb_req_o.stb) begin
            if (!req_seen) begin
                req_seen = 1'b1;
                draw_bits(2, bits);
                waits_left = bits;
            end
            if (waits_left == 0) begin
                lookup_word(wb_req_o.adr, w);
                rsp.ack  = 1'b1;
                rsp.dat  = w;
                req_seen = 1'b0;
            end else begin
                waits_left--;
            end
        end
        wb_rsp_i = rsp;
    endtask

    task automatic drive_inputs();
        draw_bits(1, bits);
        ack_i  = bits[0];
        halt_i = (halt_left > 0);
        if (halt_left > 0)
            halt_left--;
    endtask

    // Halt burst of 0 to 3 cycles for about half of the items
    task automatic pick_halt();
        draw_bits(3, bits);
        halt_left = bits[2] ? int'(bits[1:0]) : 0;
    endtask

    task automatic check_item(input int idx);
        dec_instr_t e;
        e = exp_tab[idx];
        compare(instr_o.pc, e.pc, $sformatf("row %0d pc", idx));
        compare(instr_o.raw, e.raw, $sformatf("row %0d raw", idx));
        compare(32'(instr_o.cls), 32'(e.cls), $sformatf("row %0d cls", idx));
        compare(32'(instr_o.rd), 32'(e.rd), $sformatf("row %0d rd", idx));
        compare(32'(instr_o.rs1), 32'(e.rs1), $sformatf("row %0d rs1", idx));
        compare(32'(instr_o.rs2), 32'(e.rs2), $sformatf("row %0d rs2", idx));
        compare(32'(instr_o.funct3), 32'(e.funct3), $sformatf("row %0d funct3", idx));
        compare(32'(instr_o.funct7), 32'(e.funct7), $sformatf("row %0d funct7", idx));
        compare(instr_o.imm, e.imm, $sformatf("row %0d imm", idx));
    endtask

    // ----------------------------------------
    // Program and expected stream
    // ----------------------------------------
    task automatic load_tables();
        // sub, addi -12, lw, sw -4, beq -16, lui, auipc, illegal, jal +0x40
        set_word( 0, 32'h100, 32'h4020_81b3);
        set_word( 1, 32'h104, 32'hff43_0293);
        set_word( 2, 32'h108, 32'h0081_2383);
        set_word( 3, 32'h10c, 32'hfe94_2e23);
        set_word( 4, 32'h110, 32'hfe20_88e3);
        set_word( 5, 32'h114, 32'h1234_5537);
        set_word( 6, 32'h118, 32'hffff_f597);
        set_word( 7, 32'h11c, 32'hffff_ffff);
        set_word( 8, 32'h120, 32'h0400_00ef);
        // Wrong path after each jump that never comes out
        set_word( 9, 32'h124, 32'h0000_0013);
        set_word(10, 32'h128, 32'h0000_0013);
        // lh -1 then jal to itself
        set_word(11, 32'h130, 32'hfff7_9703);
        set_word(12, 32'h134, 32'h0000_006f);
        set_word(13, 32'h138, 32'h0000_0013);
        set_word(14, 32'h13c, 32'h0000_0013);
        // addi +1 and jal back to 0x130
        set_word(15, 32'h160, 32'h0016_0613);
        set_word(16, 32'h164, 32'hfcdf_f06f);
        set_word(17, 32'h168, 32'h0000_0013);
        set_word(18, 32'h16c, 32'h0000_0013);

        //        pc      raw           cls        rd  rs1 rs2 f3    f7     imm
        set_row( 0, 32'h100, 32'h402081b3, C_ALU_R,    3,  1,  2, 3'd0, 7'h20, 32'h00000000);
        set_row( 1, 32'h104, 32'hff430293, C_ALU_I,    5,  6, 20, 3'd0, 7'h7f, 32'hfffffff4);
        set_row( 2, 32'h108, 32'h00812383, C_LOAD,     7,  2,  8, 3'd2, 7'h00, 32'h00000008);
        set_row( 3, 32'h10c, 32'hfe942e23, C_STORE,   28,  8,  9, 3'd2, 7'h7f, 32'hfffffffc);
        set_row( 4, 32'h110, 32'hfe2088e3, C_BRANCH,  17,  1,  2, 3'd0, 7'h7f, 32'hfffffff0);
        set_row( 5, 32'h114, 32'h12345537, C_UPPER,   10,  8,  3, 3'd5, 7'h09, 32'h12345000);
        set_row( 6, 32'h118, 32'hfffff597, C_UPPER,   11, 31, 31, 3'd7, 7'h7f, 32'hfffff000);
        set_row( 7, 32'h11c, 32'hffffffff, C_ILLEGAL, 31, 31, 31, 3'd7, 7'h7f, 32'h00000000);
        set_row( 8, 32'h120, 32'h040000ef, C_JUMP,     1,  0,  0, 3'd0, 7'h02, 32'h00000040);
        set_row( 9, 32'h160, 32'h00160613, C_ALU_I,   12, 12,  1, 3'd0, 7'h00, 32'h00000001);
        set_row(10, 32'h164, 32'hfcdff06f, C_JUMP,     0, 31, 13, 3'd7, 7'h7e, 32'hffffffcc);
        set_row(11, 32'h130, 32'hfff79703, C_LOAD,    14, 15, 31, 3'd1, 7'h7f, 32'hffffffff);
        set_row(12, 32'h134, 32'h0000006f, C_JUMP,     0,  0,  0, 3'd0, 7'h00, 32'h00000000);
        set_row(13, 32'h134, 32'h0000006f, C_JUMP,     0,  0,  0, 3'd0, 7'h00, 32'h00000000);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        lfsr       = 32'hf917_8269;
        rstn_i     = 1'b0;
        halt_i     = 1'b0;
        ack_i      = 1'b0;
        wb_rsp_i   = '0;
        row        = 0;
        cycles     = 0;
        halt_left  = 0;
        waits_left = 0;
        req_seen   = 1'b0;
        load_tables();

        repeat (3) @(posedge clk);
        #1;
        rstn_i = 1'b1;
        @(negedge clk);
        compare(dbg_pc_o, 32'h100, "boot pc");
        pick_halt();

        // Inputs at +1 ns and bus answer at +2 ns with outputs sampled mid cycle
        while (row < N_ROWS) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                fail_run($sformatf("Timeout after %0d cycles with %0d items seen", cycles, row));
            #1;
            if (UUT.chk_i.fail_cnt != 0)
                fail_run("A bus or decode output assertion failed");
            drive_inputs();
            #1;
            bus_respond();
            @(negedge clk);
            if (valid_o && ack_i) begin
                check_item(row);
                row++;
                pick_halt();
            end
        end

        // Last handshake edge still goes through the assertions
        @(posedge clk);
        #1;
        if (UUT.chk_i.fail_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_run("A bus or decode output assertion failed");
        end
    end

endmodule

// ==== frontend_top.f ====
hdl/wb_pkg.sv
hdl/rv_pkg.sv
hdl/load_unit.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/frontend_top.sv
verification/frontend_chk.sv
verification/tb_frontend.sv

// ==== Bender.yml ====
package:
  name: rv32i_frontend

sources:
  - hdl/wb_pkg.sv
  - hdl/rv_pkg.sv
  - hdl/load_unit.sv
  - hdl/if_stage.sv
  - hdl/id_stage.sv
  - hdl/frontend_top.sv
  - target: test
    files:
      - verification/frontend_chk.sv
      - verification/tb_frontend.sv
